//--- verification/spi_patterns.txt
# columns: command word (3 hex digits), then expected read byte (2 hex digits)
# or -- for a write command
300 00
8a5 --
000 a5
93c --
aff --
1c7 3c
2aa ff
f81 --
c5a --
700 81
400 5a
8ee --
0ff ee
d01 --
500 01
600 00
b77 --
3ff 77

//--- tb.f
+incdir+common
common/spi_pkg.sv
design/spi_cmd_stage.sv
spi_engine/spi_clk_gen.sv
spi_engine/spi_shift_fsm.sv
design/spi_master_top.sv
verification/spi_checker.sv
verification/spi_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module spi_tb -f tb.f
	out=$$(./obj_dir/Vspi_tb); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- verification/spi_tb.sv
`include "spi_macros.svh"

module spi_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                      clk;
  logic                      rst_n;
  logic [`SPI_CMD_BITS-1:0]  cmd_in;
  logic                      cmd_vld;
  logic                      cmd_rdy;
  logic                      sclk;
  logic                      cs;
  logic                      mosi;
  logic                      miso;
  logic                      read_vld;
  logic [`SPI_DATA_BITS-1:0] read_data;

  logic [`SPI_CMD_BITS-1:0]  pat_cmd[$];
  int                        pat_exp[$];            // -1 marks a write
  int                        frame_q[$];            // accepted patterns in wire order
  int                        read_q[$];             // reads still waiting for read_vld
  logic [7:0]                slave_regs[8] = '{default: 8'h00};
  logic [`SPI_CMD_BITS-1:0]  rx_word;
  logic [`SPI_CMD_BITS-1:0]  hdr;
  logic                      slv_read = 1'b0;
  logic [2:0]                slv_addr = '0;
  int                        rx_cnt = 0;
  int                        cs_falls = 0;
  int                        errors = 0;
  int                        checks = 0;
  bit                        loaded = 1'b0;

  spi_master_top u_spi_master_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  bind spi_shift_fsm spi_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .cs         (cs),
    .sclk_rise  (sclk_rise),
    .sclk_fall  (sclk_fall),
    .pend_vld   (pend_vld),
    .frame_take (frame_take),
    .read_vld   (read_vld),
    .state      (state)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = !clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("ERROR: %s", what);
    end
  endtask

  task automatic load_patterns();
    int                       fd;
    string                    line;
    string                    tok;
    logic [`SPI_CMD_BITS-1:0] word;
    fd = $fopen("verification/spi_patterns.txt", "r");
    expect_true(fd != 0, "the pattern file could not be opened");
    while (fd != 0 && $fgets(line, fd) != 0)
    begin
      if (line.len() > 0 && line[0] != "#")
      begin
        if ($sscanf(line, "%h %s", word, tok) == 2)
        begin
          expect_true((tok == "--") == word[`SPI_OP_BIT],
                      $sformatf("pattern %0d has a marker that does not fit its opcode",
                                pat_cmd.size()));
          pat_cmd.push_back(word);
          pat_exp.push_back((tok == "--") ? -1 : tok.atohex());
        end
      end
    end
    if (fd != 0)
      $fclose(fd);
    expect_true(pat_cmd.size() > 0, "the pattern file holds no commands");
    loaded = 1'b1;
  endtask

  // called at posedge + 1 ns, returns at posedge + 1 ns after the accepting edge
  task automatic send_command(input int idx);
    bit taken;
    cmd_in  = pat_cmd[idx];
    cmd_vld = 1'b1;
    taken   = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      taken = cmd_rdy;
      @(posedge clk);
    end
    #1;
    frame_q.push_back(idx);
    if (!pat_cmd[idx][`SPI_OP_BIT])
      read_q.push_back(idx);
  endtask

  // mode 0 slave model
  always @(negedge cs)
    cs_falls++;

  always @(posedge sclk)
  begin
    if (!cs)
    begin
      rx_word = {rx_word[`SPI_CMD_BITS-2:0], mosi};
      rx_cnt++;
      if (rx_cnt == `SPI_HDR_BITS)
      begin
        hdr      = rx_word << `SPI_DATA_BITS;   // header back in command word position
        slv_read = !hdr[`SPI_OP_BIT];
        slv_addr = hdr[`SPI_ADDR_MSB:`SPI_ADDR_LSB];
      end
    end
  end

  always @(negedge sclk)
  begin
    if (!cs && slv_read && rx_cnt >= `SPI_HDR_BITS && rx_cnt < `SPI_CMD_BITS)
      miso = slave_regs[slv_addr][`SPI_CMD_BITS-1-rx_cnt];   // msb first
    else
      miso = 1'b0;
  end

  always @(posedge cs or negedge rst_n)
  begin : frame_end
    int                       idx;
    logic [`SPI_CMD_BITS-1:0] exp_word;
    if (!rst_n)
    begin
      foreach (slave_regs[i])
        slave_regs[i] = '0;
    end
    else if (frame_q.size() == 0)
      expect_true(1'b0, "a frame appeared on the wire with no command accepted");
    else
    begin
      idx      = frame_q.pop_front();
      exp_word = pat_cmd[idx];
      if (!exp_word[`SPI_OP_BIT])
        exp_word[`SPI_DATA_BITS-1:0] = '0;   // data phase of a read stays low
      check_value($sformatf("pattern %0d mosi bits", idx), exp_word, rx_word);
      check_value($sformatf("pattern %0d sclk rises", idx), `SPI_CMD_BITS, rx_cnt);
      if (rx_word[`SPI_OP_BIT])
        slave_regs[rx_word[`SPI_ADDR_MSB:`SPI_ADDR_LSB]] = rx_word[`SPI_DATA_BITS-1:0];
    end
    rx_cnt = 0;
  end

  always @(negedge clk)
  begin : read_monitor
    int idx;
    if (rst_n && read_vld)
    begin
      expect_true(read_q.size() != 0, "unexpected read result with no read outstanding");
      if (read_q.size() != 0)
      begin
        idx = read_q.pop_front();
        check_value($sformatf("pattern %0d read_data", idx), pat_exp[idx], read_data);
      end
    end
  end

  initial
  begin
    int gap;
    void'($urandom(46489));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    miso    = 1'b0;
    load_patterns();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset cs", 1, cs);
    check_value("reset sclk", 0, sclk);
    check_value("reset mosi", 0, mosi);
    check_value("reset read_vld", 0, read_vld);
    check_value("reset cmd_rdy", 1, cmd_rdy);
    @(posedge clk);
    #1;
    for (int i = 0; i < pat_cmd.size(); i++)
    begin
      gap = $urandom % 4;
      if (gap != 0)
      begin
        cmd_vld = 1'b0;
        repeat (gap) @(posedge clk);
        #1;
      end
      send_command(i);
    end
    cmd_vld = 1'b0;
    while (cs_falls < pat_cmd.size() || !cs || frame_q.size() != 0 || read_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    check_value("cs falling edges", pat_cmd.size(), cs_falls);
    $display("checks %0d, errors %0d, frames %0d", checks, errors, cs_falls);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    wait (loaded);
    #((pat_cmd.size() + 2) * 13 * 2 * `SPI_HALF_PERIOD * 2 * 8);
    $display("ERROR: timeout, the commands did not complete in time (%0d errors)", errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- verification/spi_checker.sv
module spi_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                cs,
  input logic                sclk_rise,
  input logic                sclk_fall,
  input logic                pend_vld,
  input logic                frame_take,
  input logic                read_vld,
  input spi_pkg::spi_state_e state
);

  timeunit 1ns;
  timeprecision 100ps;

  // sclk moves only on a strobe, so no strobe may come while cs is high
  cs_high_sclk_low: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> !sclk_rise && !sclk_fall)
    else $error("sclk strobe while cs is high");

  read_vld_after_hold: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> $past(state) == spi_pkg::st_hold)
    else $error("read_vld outside the cycle after st_hold");

  // the command stage frees its slot right after the take
  take_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    frame_take |-> state == spi_pkg::st_idle ##1 !pend_vld)
    else $error("frame_take outside st_idle or the pending slot not freed");

endmodule

//--- design/spi_master_top.sv
`include "spi_macros.svh"

module spi_master_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`SPI_CMD_BITS-1:0]   cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       sclk,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       read_vld,
  output logic [`SPI_DATA_BITS-1:0]  read_data
);

  spi_pkg::spi_frame_t pend_frame;
  logic                pend_vld;
  logic                frame_take;
  logic                clk_run;
  logic                sclk_rise;
  logic                sclk_fall;

  spi_cmd_stage u_cmd_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .frame_take (frame_take),
    .pend_frame (pend_frame),
    .pend_vld   (pend_vld)
  );

  spi_clk_gen u_clk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .clk_run   (clk_run),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_shift_fsm u_shift_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .pend_frame (pend_frame),
    .pend_vld   (pend_vld),
    .frame_take (frame_take),
    .clk_run    (clk_run),
    .sclk_rise  (sclk_rise),
    .sclk_fall  (sclk_fall),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

endmodule

//--- spi_engine/spi_shift_fsm.sv
`include "spi_macros.svh"

module spi_shift_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  spi_pkg::spi_frame_t        pend_frame,
  input  logic                       pend_vld,
  output logic                       frame_take,
  output logic                       clk_run,
  input  logic                       sclk_rise,
  input  logic                       sclk_fall,
  output logic                       cs,
  output logic                       mosi,
  input  logic                       miso,
  output logic                       read_vld,
  output logic [`SPI_DATA_BITS-1:0]  read_data
);

  spi_pkg::spi_state_e         state;
  spi_pkg::spi_op_e            frame_op;
  logic [`SPI_CMD_BITS-1:0]    tx_sr;
  logic [`SPI_DATA_BITS-1:0]   rx_sr;
  logic [3:0]                  bit_cnt;     // sclk rises seen in this frame
  logic                        last_bit;
  logic                        in_data;
  logic                        hold_done;
  logic                        shift_out;
  logic                        sample;

  assign frame_take = (state == spi_pkg::st_idle) && pend_vld;
  assign last_bit   = (bit_cnt == 4'(`SPI_CMD_BITS));
  assign in_data    = (frame_op == spi_pkg::op_read) && (bit_cnt >= 4'(`SPI_HDR_BITS));

  // the half period after the last fall ends where the next rise would be;
  // clk_run drops in that cycle so sclk never goes high again
  assign hold_done = (state == spi_pkg::st_hold) && sclk_rise;
  assign clk_run   = (state != spi_pkg::st_idle) && !hold_done;

  assign shift_out = (state == spi_pkg::st_shift) && sclk_fall && !last_bit;
  assign sample    = (state == spi_pkg::st_shift) && sclk_rise && in_data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= spi_pkg::st_idle;
      cs        <= 1'b1;
      mosi      <= 1'b0;
      bit_cnt   <= '0;
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        spi_pkg::st_idle:
        begin
          if (frame_take)
          begin
            state   <= spi_pkg::st_setup;
            cs      <= 1'b0;
            mosi    <= pend_frame[`SPI_CMD_BITS-1];   // first bit out at entry
            bit_cnt <= '0;
          end
        end
        spi_pkg::st_setup:
        begin
          if (sclk_rise)
          begin
            state   <= spi_pkg::st_shift;
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        spi_pkg::st_shift:
        begin
          if (sclk_rise)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (sclk_fall && last_bit)
          begin
            state <= spi_pkg::st_hold;
            mosi  <= 1'b0;
          end
          else if (shift_out)
          begin
            mosi <= in_data ? 1'b0 : tx_sr[`SPI_CMD_BITS-2];
          end
        end
        spi_pkg::st_hold:
        begin
          if (hold_done)
          begin
            state     <= spi_pkg::st_idle;
            cs        <= 1'b1;
            read_vld  <= (frame_op == spi_pkg::op_read);
            if (frame_op == spi_pkg::op_read)
            begin
              read_data <= rx_sr;
            end
          end
        end
        default:
        begin
          state <= spi_pkg::st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (frame_take)
    begin
      tx_sr    <= pend_frame;
      frame_op <= pend_frame.op;
    end
    else if (shift_out)
    begin
      tx_sr <= {tx_sr[`SPI_CMD_BITS-2:0], 1'b0};
    end
    if (sample)
    begin
      rx_sr <= {rx_sr[`SPI_DATA_BITS-2:0], miso};   // msb first
    end
  end

endmodule

//--- spi_engine/spi_clk_gen.sv
`include "spi_macros.svh"

module spi_clk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic clk_run,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  localparam int cnt_w = $clog2(`SPI_HALF_PERIOD) + 1;

  logic [cnt_w-1:0] cnt;
  logic             cnt_done;

  // counter sits at zero while idle, so the strobes stay quiet
  assign cnt_done  = (cnt == cnt_w'(`SPI_HALF_PERIOD - 1));
  assign sclk_rise = cnt_done && !sclk;   // sclk goes high on this edge
  assign sclk_fall = cnt_done && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (!clk_run)
    begin
      cnt  <= '0;                          // next frame starts with a full half period
      sclk <= 1'b0;
    end
    else if (cnt_done)
    begin
      cnt  <= '0;
      sclk <= !sclk;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- design/spi_cmd_stage.sv
`include "spi_macros.svh"

module spi_cmd_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`SPI_CMD_BITS-1:0]  cmd_in,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  input  logic                      frame_take,
  output spi_pkg::spi_frame_t       pend_frame,
  output logic                      pend_vld
);

  spi_pkg::spi_frame_t dec_frame;
  logic                accept;

  assign cmd_rdy = !pend_vld;            // room for one frame
  assign accept  = cmd_vld && cmd_rdy;

  always_comb
  begin
    dec_frame.op   = spi_pkg::spi_op_e'(cmd_in[`SPI_OP_BIT]);
    dec_frame.addr = cmd_in[`SPI_ADDR_MSB:`SPI_ADDR_LSB];
    // reads carry no payload, keep mosi quiet in the data phase
    if (dec_frame.op == spi_pkg::op_write)
    begin
      dec_frame.wdata = cmd_in[`SPI_WDATA_MSB:`SPI_WDATA_LSB];
    end
    else
    begin
      dec_frame.wdata = '0;
    end
  end

  // slot occupancy, set on accept and cleared when the engine takes it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_vld <= 1'b0;
    end
    else if (accept)
    begin
      pend_vld <= 1'b1;
    end
    else if (frame_take)
    begin
      pend_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pend_frame <= dec_frame;
    end
  end

endmodule

//--- common/spi_pkg.sv
`include "spi_macros.svh"

package spi_pkg;

  // command bit 11
  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } spi_op_e;

  typedef enum logic [1:0]
  {
    st_idle  = 2'd0,
    st_setup = 2'd1,   // cs low, first half period before the first rise
    st_shift = 2'd2,
    st_hold  = 2'd3    // last half period, sclk back low
  } spi_state_e;

  // same bit order as the command word, op in the msb
  typedef struct packed
  {
    spi_op_e                                    op;
    logic [`SPI_ADDR_MSB-`SPI_ADDR_LSB:0]       addr;
    logic [`SPI_DATA_BITS-1:0]                  wdata;
  } spi_frame_t;

endpackage

//--- common/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

`define SPI_HALF_PERIOD 4   // clk cycles per sclk half period

// frame lengths, in sclk cycles
`define SPI_CMD_BITS  12
`define SPI_HDR_BITS  4
`define SPI_DATA_BITS 8

// command word layout
`define SPI_OP_BIT     11
`define SPI_ADDR_MSB   10
`define SPI_ADDR_LSB   8
`define SPI_WDATA_MSB  7
`define SPI_WDATA_LSB  0

`endif
